/* bench/mlsdTb.sv */
`timescale 1ns/1ns
`include "mlsd_config.svh"

module mlsdTb import mlsdPkg::*; ();

	localparam int clkPeriod      = 20;
	localparam int beatsEnableOff = 40;
	localparam int beatsClean     = 150;
	localparam int beatsNoisy     = 150;
	localparam int maxBeats       = 150;
	localparam int maxGap         = 3;
	localparam int axiOps         = 16;
	localparam int axiOpCycles    = 12;
	localparam int resetCycles    = 4 * (8 + 2);
	localparam int drainCycles    = 4 * 24;
	localparam int streamCycles   = beatsEnableOff + beatsClean + (maxGap + 1) * beatsNoisy;
	localparam int watchdogCycles = streamCycles + 50 + axiOps * axiOpCycles
		+ resetCycles + drainCycles;

	logic                    clk = 1'b0;
	logic                    rstN_i;
	axiLiteReq_t             axiReq;
	axiLiteRsp_t             axiRsp;
	laneBeat_t               inBeat_i;
	logic                    inValid_i;
	logic [`MLSD_LANES-1:0] outBits_o;
	logic                    outValid_o;

	integer                  seed;
	int                      errCount;
	int                      checkCount;
	int                      outCount;
	int                      cycleCount;
	int                      tapsModel [`MLSD_TAPS];
	logic                    enableModel;
	logic                    trueBits [4*maxBeats];
	logic                    streamBits [4*maxBeats];
	int                      streamCodes [4*maxBeats];
	logic [`MLSD_LANES-1:0] expQ [$];
	int                      dueQ [$];

	mlsdTop u_mlsdTop (
		.clk        (clk),
		.rstN_i     (rstN_i),
		.axiReq_i   (axiReq),
		.axiRsp_o   (axiRsp),
		.inBeat_i   (inBeat_i),
		.inValid_i  (inValid_i),
		.outBits_o  (outBits_o),
		.outValid_o (outValid_o)
	);

	always #(clkPeriod / 2) clk = ~clk;

	always @(posedge clk)
		cycleCount++;

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			errCount++;
			$display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic resetDut();
		@(posedge clk);
		#2;
		rstN_i    = 1'b0;
		inValid_i = 1'b0;
		repeat (8) @(posedge clk);
		#2;
		rstN_i = 1'b1;
		foreach (tapsModel[j])
			tapsModel[j] = 0;
		enableModel = 1'b1;
	endtask

	task automatic axiWrite(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int waitCycles;
		waitCycles = 0;
		@(posedge clk);
		#2;
		axiReq.awaddr  = addr;
		axiReq.awvalid = 1'b1;
		axiReq.wdata   = data;
		axiReq.wstrb   = strb;
		axiReq.wvalid  = 1'b1;
		axiReq.bready  = 1'b1;
		@(negedge clk);
		while (axiRsp.awready !== 1'b1 && waitCycles < 16) begin
			@(negedge clk);
			waitCycles++;
		end
		assert (axiRsp.awready === 1'b1) else begin
			errCount++;
			$display("AXI write to address %h was never accepted", addr);
		end
		checkValue("wready", axiRsp.wready, 1'b1);
		@(posedge clk);
		#2;
		axiReq.awvalid = 1'b0;
		axiReq.wvalid  = 1'b0;
		waitCycles = 0;
		@(negedge clk);
		while (axiRsp.bvalid !== 1'b1 && waitCycles < 16) begin
			@(negedge clk);
			waitCycles++;
		end
		checkValue("bvalid", axiRsp.bvalid, 1'b1);
		checkValue("bresp", axiRsp.bresp, `MLSD_RESP_OKAY);
		@(posedge clk);
		#2;
		axiReq.bready = 1'b0;
	endtask

	task automatic axiRead(input logic [31:0] addr, output logic [31:0] data);
		int waitCycles;
		waitCycles = 0;
		@(posedge clk);
		#2;
		axiReq.araddr  = addr;
		axiReq.arvalid = 1'b1;
		axiReq.rready  = 1'b1;
		@(negedge clk);
		while (axiRsp.arready !== 1'b1 && waitCycles < 16) begin
			@(negedge clk);
			waitCycles++;
		end
		assert (axiRsp.arready === 1'b1) else begin
			errCount++;
			$display("AXI read of address %h was never accepted", addr);
		end
		@(posedge clk);
		#2;
		axiReq.arvalid = 1'b0;
		waitCycles = 0;
		@(negedge clk);
		while (axiRsp.rvalid !== 1'b1 && waitCycles < 16) begin
			@(negedge clk);
			waitCycles++;
		end
		checkValue("rvalid", axiRsp.rvalid, 1'b1);
		checkValue("rresp", axiRsp.rresp, `MLSD_RESP_OKAY);
		data = axiRsp.rdata;
		@(posedge clk);
		#2;
		axiReq.rready = 1'b0;
	endtask

	// Tap 0 sits in the low byte.
	task automatic programTaps(input logic [31:0] word);
		axiWrite(`MLSD_ADDR_TAPS, word, 4'hf);
		for (int j = 0; j < `MLSD_TAPS; j++)
			tapsModel[j] = $signed(word[8*j +: 8]);
	endtask

	task automatic setEnable(input logic en);
		axiWrite(`MLSD_ADDR_CTRL, {31'd0, en}, 4'h1);
		enableModel = en;
	endtask

	// Symbols are +1 or -1, and -1 before the first position.
	function automatic int trueSym(input int pos);
		if (pos < 0)
			return -1;
		return trueBits[pos] ? 1 : -1;
	endfunction

	function automatic int estSym(input int pos);
		if (pos < 0)
			return -1;
		return streamBits[pos] ? 1 : -1;
	endfunction

	function automatic int codeAt(input int pos);
		if (pos < 0)
			return 0;
		return streamCodes[pos];
	endfunction

	// Expected decisions for every lane of one beat in serial order.
	function automatic logic [`MLSD_LANES-1:0] refBits(input int beat);
		logic [`MLSD_LANES-1:0] result;
		int                      energy [2];
		int                      expCode;
		int                      sym;
		int                      err;
		int                      n;
		for (int lane = 0; lane < `MLSD_LANES; lane++) begin
			n = `MLSD_LANES * beat + lane;
			for (int h = 0; h < 2; h++) begin
				energy[h] = 0;
				for (int m = n; m < n + `MLSD_SEQ; m++) begin
					expCode = 0;
					for (int j = 0; j < `MLSD_TAPS; j++) begin
						if (m - j == n)
							sym = (h == 1) ? 1 : -1;
						else
							sym = estSym(m - j);
						expCode += tapsModel[j] * sym;
					end
					err = codeAt(m) - expCode;
					energy[h] += err * err;
				end
			end
			if (!enableModel || energy[0] == energy[1])
				result[lane] = streamBits[n];
			else
				result[lane] = energy[1] < energy[0];
		end
		return result;
	endfunction

	function automatic laneBeat_t beatAt(input int beat);
		laneBeat_t b;
		for (int lane = 0; lane < `MLSD_LANES; lane++) begin
			b.codes[lane] = code_t'(streamCodes[`MLSD_LANES * beat + lane]);
			b.bits[lane]  = streamBits[`MLSD_LANES * beat + lane];
		end
		return b;
	endfunction

	task automatic runStream(input int beats, input int noiseAmp, input int flipPct,
		input int gapMax);
		integer rnd;
		int     conv;
		int     idle;
		int     waitCycles;
		for (int pos = 0; pos < `MLSD_LANES * beats; pos++) begin
			rnd = $random(seed);
			trueBits[pos] = rnd[0];
		end
		for (int pos = 0; pos < `MLSD_LANES * beats; pos++) begin
			conv = 0;
			for (int j = 0; j < `MLSD_TAPS; j++)
				conv += tapsModel[j] * trueSym(pos - j);
			if (noiseAmp > 0)
				conv += $random(seed) % (noiseAmp + 1);
			streamCodes[pos] = conv;
			rnd = $random(seed);
			if ($unsigned(rnd) % 100 < flipPct)
				streamBits[pos] = !trueBits[pos];
			else
				streamBits[pos] = trueBits[pos];
		end
		outCount = 0;
		for (int k = 0; k < beats; k++) begin
			idle = (gapMax > 0) ? $unsigned($random(seed)) % (gapMax + 1) : 0;
			repeat (idle) begin
				@(posedge clk);
				#2;
				inValid_i = 1'b0;
			end
			@(posedge clk);
			#2;
			inBeat_i  = beatAt(k);
			inValid_i = 1'b1;
			// A beat is decided once its successor is in.
			if (k > 0) begin
				expQ.push_back(refBits(k - 1));
				// Accepted on the next edge, out three cycles later.
				dueQ.push_back(cycleCount + 3);
			end
		end
		@(posedge clk);
		#2;
		inValid_i = 1'b0;
		waitCycles = 0;
		while (expQ.size() > 0 && waitCycles < 20) begin
			@(negedge clk);
			waitCycles++;
		end
		repeat (4) @(negedge clk);
		assert (expQ.size() == 0) else begin
			errCount++;
			$display("Stream ended with %0d expected beats never output", expQ.size());
			expQ.delete();
			dueQ.delete();
		end
		checkValue("outCount", outCount, beats - 1);
	endtask

	// Comparator.
	always @(negedge clk) begin
		logic [`MLSD_LANES-1:0] expBits;
		int                      due;
		if (rstN_i === 1'b1 && outValid_o === 1'b1) begin
			outCount++;
			assert (expQ.size() > 0) else begin
				errCount++;
				$display("Output at %0t arrived with no expected beat pending", $time);
			end
			if (expQ.size() > 0) begin
				expBits = expQ.pop_front();
				due     = dueQ.pop_front();
				checkCount++;
				assert (outBits_o === expBits) else begin
					errCount++;
					$display("ERR t=%0t outBits_o got %b expected %b", $time,
						outBits_o, expBits);
				end
				assert (cycleCount == due) else begin
					errCount++;
					$display("Output at %0t arrived in cycle %0d instead of cycle %0d",
						$time, cycleCount, due);
				end
			end
		end
	end

	initial begin
		#(watchdogCycles * clkPeriod);
		$display("Watchdog expired at %0t before the run finished", $time);
		$display("Summary: %0d errors, %0d beats checked", errCount + 1, checkCount);
		$display("tests failed");
		$finish;
	end

	initial begin
		logic [31:0] data;
		seed        = 32'h1b47;
		rstN_i      = 1'b0;
		axiReq      = '0;
		inBeat_i    = '0;
		inValid_i   = 1'b0;
		errCount    = 0;
		checkCount  = 0;
		outCount    = 0;
		cycleCount  = 0;
		enableModel = 1'b1;
		resetDut();

		// Reset values.
		@(negedge clk);
		checkValue("outValid_o", outValid_o, 1'b0);
		checkValue("awready", axiRsp.awready, 1'b0);
		checkValue("wready", axiRsp.wready, 1'b0);
		checkValue("bvalid", axiRsp.bvalid, 1'b0);
		checkValue("arready", axiRsp.arready, 1'b0);
		checkValue("rvalid", axiRsp.rvalid, 1'b0);
		axiRead(`MLSD_ADDR_CTRL, data);
		checkValue("ctrl rdata", data, 32'h1);
		axiRead(`MLSD_ADDR_TAPS, data);
		checkValue("taps rdata", data, 32'h0);

		// Byte strobes merge into the tap word.
		axiWrite(`MLSD_ADDR_TAPS, 32'h1122_3344, 4'hf);
		axiRead(`MLSD_ADDR_TAPS, data);
		checkValue("taps rdata", data, 32'h1122_3344);
		axiWrite(`MLSD_ADDR_TAPS, 32'haabb_ccdd, 4'b0101);
		axiRead(`MLSD_ADDR_TAPS, data);
		checkValue("taps rdata", data, 32'h11bb_33dd);
		axiWrite(32'h8, 32'hdead_beef, 4'hf);
		axiRead(32'h8, data);
		checkValue("unmapped rdata", data, 32'h0);

		// Detector bypassed.
		resetDut();
		programTaps(32'h0102_0305);
		setEnable(1'b0);
		runStream(beatsEnableOff, 0, 20, 0);

		// Clean codes, flipped estimates.
		resetDut();
		programTaps(32'h0102_0305);
		setEnable(1'b1);
		runStream(beatsClean, 0, 10, 0);

		// Noisy codes with gaps in the stream.
		resetDut();
		programTaps(32'h0102_0305);
		runStream(beatsNoisy, 3, 15, maxGap);

		$display("Summary: %0d errors, %0d beats checked", errCount, checkCount);
		if (errCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* design/chanEstRegs.sv */
`timescale 1ns/1ns
`include "mlsd_config.svh"

module chanEstRegs import mlsdPkg::*; (
	input  logic        clk,
	input  logic        rstN_i,
	input  axiLiteReq_t axiReq_i,
	output axiLiteRsp_t axiRsp_o,
	output tapWord_u    taps_o,
	output logic        enable_o
);

	logic                        awReady;
	logic                        wReady;
	logic                        bValid;
	logic                        arReady;
	logic                        rValid;
	logic [`MLSD_AXI_DATA_W-1:0] rData;
	logic [`MLSD_AXI_DATA_W-1:0] readWord;
	tapWord_u                    tapsQ;
	logic                        enableQ;

	// Write path.
	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			awReady <= 1'b0;
			wReady  <= 1'b0;
			bValid  <= 1'b0;
			tapsQ   <= '0;
			enableQ <= 1'b1;
		end else begin
			awReady <= 1'b0;
			wReady  <= 1'b0;
			// Accept address and data together, one write in flight.
			if (axiReq_i.awvalid && axiReq_i.wvalid && !awReady && !bValid) begin
				awReady <= 1'b1;
				wReady  <= 1'b1;
			end
			if (awReady) begin
				bValid <= 1'b1;
				if (axiReq_i.awaddr == `MLSD_ADDR_TAPS) begin
					for (int b = 0; b < `MLSD_AXI_DATA_W/8; b++) begin
						if (axiReq_i.wstrb[b])
							tapsQ.raw[8*b +: 8] <= axiReq_i.wdata[8*b +: 8];
					end
				end else if (axiReq_i.awaddr == `MLSD_ADDR_CTRL) begin
					if (axiReq_i.wstrb[0])
						enableQ <= axiReq_i.wdata[0];
				end
			end else if (bValid && axiReq_i.bready) begin
				bValid <= 1'b0;
			end
		end
	end

	// Read decode, unmapped addresses give zero.
	always_comb begin
		readWord = '0;
		if (axiReq_i.araddr == `MLSD_ADDR_TAPS)
			readWord = tapsQ.raw;
		else if (axiReq_i.araddr == `MLSD_ADDR_CTRL)
			readWord[0] = enableQ;
	end

	// Read handshake.
	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			arReady <= 1'b0;
			rValid  <= 1'b0;
		end else begin
			arReady <= 1'b0;
			if (axiReq_i.arvalid && !arReady && !rValid)
				arReady <= 1'b1;
			if (arReady)
				rValid <= 1'b1;
			else if (rValid && axiReq_i.rready)
				rValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (arReady)
			rData <= readWord;
	end

	assign axiRsp_o = '{
		awready: awReady,
		wready:  wReady,
		bresp:   `MLSD_RESP_OKAY,
		bvalid:  bValid,
		arready: arReady,
		rdata:   rData,
		rresp:   `MLSD_RESP_OKAY,
		rvalid:  rValid
	};

	assign taps_o   = tapsQ;
	assign enable_o = enableQ;

	// Responses are held until the host takes them.
	assert property (@(posedge clk) disable iff (!rstN_i)
		bValid && !axiReq_i.bready |=> bValid);

	assert property (@(posedge clk) disable iff (!rstN_i)
		rValid && !axiReq_i.rready |=> rValid && $stable(rData));

endmodule

/* design/codeBuffer.sv */
`timescale 1ns/1ns
`include "mlsd_config.svh"

module codeBuffer import mlsdPkg::*; (
	input  logic        clk,
	input  logic        rstN_i,
	input  laneBeat_t   inBeat_i,
	input  logic        inValid_i,
	output codeWindow_t window_o
);

	laneBeat_t  prevQ;
	laneBeat_t  centerQ;
	laneBeat_t  nextQ;
	logic [1:0] beatCnt;
	logic       validQ;

	// History is cleared so positions before the first beat read as zero.
	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			prevQ   <= '0;
			centerQ <= '0;
			nextQ   <= '0;
			beatCnt <= '0;
			validQ  <= 1'b0;
		end else begin
			// Center needs its successor before it can be decided.
			validQ <= inValid_i && (beatCnt != 2'd0);
			if (inValid_i) begin
				prevQ   <= centerQ;
				centerQ <= nextQ;
				nextQ   <= inBeat_i;
				if (beatCnt != 2'd2)
					beatCnt <= beatCnt + 2'd1;
			end
		end
	end

	assign window_o = '{
		codes: {nextQ.codes, centerQ.codes, prevQ.codes},
		bits:  {nextQ.bits, centerQ.bits, prevQ.bits},
		valid: validQ
	};

	// A window only follows an accepted beat.
	assert property (@(posedge clk) disable iff (!rstN_i)
		$rose(validQ) |-> $past(inValid_i));

endmodule

/* design/hypothesisSelect.sv */
`timescale 1ns/1ns
`include "mlsd_config.svh"

module hypothesisSelect import mlsdPkg::*; (
	input  logic                    clk,
	input  logic                    rstN_i,
	input  hypSeq_t                 seq_i,
	input  logic                    enable_i,
	output logic [`MLSD_LANES-1:0] outBits_o,
	output logic                    outValid_o
);

	energy_t [`MLSD_LANES-1:0][1:0] energy;
	logic [`MLSD_LANES-1:0]         bitsNext;
	logic [`MLSD_LANES-1:0]         outBitsQ;
	logic                           outValidQ;

	// Error energy over the window for each hypothesis.
	always_comb begin
		logic signed [`MLSD_ENERGY_W-1:0] diff;
		for (int lane = 0; lane < `MLSD_LANES; lane++) begin
			for (int h = 0; h < 2; h++) begin
				energy[lane][h] = '0;
				for (int m = 0; m < `MLSD_SEQ; m++) begin
					diff = seq_i.lanes[lane].obs[m] - seq_i.lanes[lane].expCodes[h][m];
					energy[lane][h] = energy[lane][h] + energy_t'(diff * diff);
				end
			end
		end
	end

	// Lower energy wins, a tie keeps the slicer decision.
	always_comb begin
		logic pick;
		for (int lane = 0; lane < `MLSD_LANES; lane++) begin
			if (energy[lane][1] < energy[lane][0])
				pick = 1'b1;
			else if (energy[lane][0] < energy[lane][1])
				pick = 1'b0;
			else
				pick = seq_i.lanes[lane].initBit;
			bitsNext[lane] = enable_i ? pick : seq_i.lanes[lane].initBit;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN_i)
			outValidQ <= 1'b0;
		else
			outValidQ <= seq_i.valid;
	end

	always_ff @(posedge clk) begin
		if (seq_i.valid)
			outBitsQ <= bitsNext;
	end

	assign outBits_o  = outBitsQ;
	assign outValid_o = outValidQ;

	assert property (@(posedge clk) disable iff (!rstN_i)
		!$isunknown(outValid_o));

endmodule

/* design/mlsdPkg.sv */
`include "mlsd_config.svh"

package mlsdPkg;

	typedef logic signed [`MLSD_CODE_W-1:0] code_t;
	typedef logic signed [`MLSD_TAP_W-1:0]  tap_t;
	typedef logic signed [`MLSD_EXP_W-1:0]  exp_t;
	typedef logic [`MLSD_ENERGY_W-1:0]      energy_t;

	// One slicer beat; a set bit stands for +1.
	typedef struct packed {
		code_t [`MLSD_LANES-1:0] codes;
		logic  [`MLSD_LANES-1:0] bits;
	} laneBeat_t;

	// Previous, center and next beat in serial order, oldest at index 0.
	typedef struct packed {
		code_t [`MLSD_WIN_BEATS*`MLSD_LANES-1:0] codes;
		logic  [`MLSD_WIN_BEATS*`MLSD_LANES-1:0] bits;
		logic                                    valid;
	} codeWindow_t;

	// Expected codes indexed by hypothesis bit, then window offset.
	typedef struct packed {
		code_t [`MLSD_SEQ-1:0]      obs;
		exp_t  [1:0][`MLSD_SEQ-1:0] expCodes;
		logic                       initBit;
	} hypLane_t;

	typedef struct packed {
		hypLane_t [`MLSD_LANES-1:0] lanes;
		logic                       valid;
	} hypSeq_t;

	// Raw register word versus signed taps, tap 0 in the low byte.
	typedef union packed {
		logic [`MLSD_AXI_DATA_W-1:0] raw;
		tap_t [`MLSD_TAPS-1:0]       taps;
	} tapWord_u;

	typedef struct packed {
		logic [`MLSD_AXI_ADDR_W-1:0]   awaddr;
		logic                          awvalid;
		logic [`MLSD_AXI_DATA_W-1:0]   wdata;
		logic [`MLSD_AXI_DATA_W/8-1:0] wstrb;
		logic                          wvalid;
		logic                          bready;
		logic [`MLSD_AXI_ADDR_W-1:0]   araddr;
		logic                          arvalid;
		logic                          rready;
	} axiLiteReq_t;

	typedef struct packed {
		logic                        awready;
		logic                        wready;
		logic [1:0]                  bresp;
		logic                        bvalid;
		logic                        arready;
		logic [`MLSD_AXI_DATA_W-1:0] rdata;
		logic [1:0]                  rresp;
		logic                        rvalid;
	} axiLiteRsp_t;

endpackage

/* design/mlsdTop.sv */
`timescale 1ns/1ns
`include "mlsd_config.svh"

module mlsdTop import mlsdPkg::*; (
	input  logic                    clk,
	input  logic                    rstN_i,
	input  axiLiteReq_t             axiReq_i,
	output axiLiteRsp_t             axiRsp_o,
	input  laneBeat_t               inBeat_i,
	input  logic                    inValid_i,
	output logic [`MLSD_LANES-1:0] outBits_o,
	output logic                    outValid_o
);

	tapWord_u    taps;
	logic        enable;
	codeWindow_t window;
	hypSeq_t     seq;

	chanEstRegs u_chanEstRegs (
		.clk      (clk),
		.rstN_i   (rstN_i),
		.axiReq_i (axiReq_i),
		.axiRsp_o (axiRsp_o),
		.taps_o   (taps),
		.enable_o (enable)
	);

	// Stage 1.
	codeBuffer u_codeBuffer (
		.clk       (clk),
		.rstN_i    (rstN_i),
		.inBeat_i  (inBeat_i),
		.inValid_i (inValid_i),
		.window_o  (window)
	);

	// Stage 2.
	seqEstimator u_seqEstimator (
		.clk      (clk),
		.rstN_i   (rstN_i),
		.window_i (window),
		.taps_i   (taps),
		.seq_o    (seq)
	);

	// Stage 3.
	hypothesisSelect u_hypothesisSelect (
		.clk        (clk),
		.rstN_i     (rstN_i),
		.seq_i      (seq),
		.enable_i   (enable),
		.outBits_o  (outBits_o),
		.outValid_o (outValid_o)
	);

endmodule

/* design/seqEstimator.sv */
`timescale 1ns/1ns
`include "mlsd_config.svh"

module seqEstimator import mlsdPkg::*; (
	input  logic        clk,
	input  logic        rstN_i,
	input  codeWindow_t window_i,
	input  tapWord_u    taps_i,
	output hypSeq_t     seq_o
);

	hypLane_t [`MLSD_LANES-1:0] lanesNext;
	hypLane_t [`MLSD_LANES-1:0] lanesQ;
	logic                       validQ;

	// Center position of lane i sits at window index LANES + i.
	always_comb begin
		logic sym;
		exp_t acc;
		lanesNext = '0;
		for (int lane = 0; lane < `MLSD_LANES; lane++) begin
			lanesNext[lane].initBit = window_i.bits[`MLSD_LANES + lane];
			for (int m = 0; m < `MLSD_SEQ; m++) begin
				lanesNext[lane].obs[m] = window_i.codes[`MLSD_LANES + lane + m];
				for (int h = 0; h < 2; h++) begin
					acc = '0;
					for (int j = 0; j < `MLSD_TAPS; j++) begin
						// Tap j lands on the center when m equals j.
						if (m == j)
							sym = h[0];
						else
							sym = window_i.bits[`MLSD_LANES + lane + m - j];
						if (sym)
							acc = acc + exp_t'(taps_i.taps[j]);
						else
							acc = acc - exp_t'(taps_i.taps[j]);
					end
					lanesNext[lane].expCodes[h][m] = acc;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN_i)
			validQ <= 1'b0;
		else
			validQ <= window_i.valid;
	end

	always_ff @(posedge clk) begin
		if (window_i.valid)
			lanesQ <= lanesNext;
	end

	assign seq_o = '{lanes: lanesQ, valid: validQ};

endmodule

/* filelist.f */
+incdir+include
design/mlsdPkg.sv
design/chanEstRegs.sv
design/codeBuffer.sv
design/seqEstimator.sv
design/hypothesisSelect.sv
design/mlsdTop.sv
bench/mlsdTb.sv

/* include/mlsd_config.svh */
`ifndef MLSD_CONFIG_SVH
`define MLSD_CONFIG_SVH

// Stream geometry.
`define MLSD_LANES      4
`define MLSD_TAPS       4
`define MLSD_SEQ        3
`define MLSD_WIN_BEATS  3

// Datapath widths.
`define MLSD_CODE_W     8
`define MLSD_TAP_W      8
`define MLSD_EXP_W      12
`define MLSD_ENERGY_W   24

// AXI4-Lite register map.
`define MLSD_AXI_ADDR_W 32
`define MLSD_AXI_DATA_W 32
`define MLSD_ADDR_TAPS  32'h0000_0000
`define MLSD_ADDR_CTRL  32'h0000_0004
`define MLSD_RESP_OKAY  2'b00

`endif
